//--- dv/i2c_slave_model.sv
`default_nettype none

// Register slave, sampled on the system clock
module i2c_slave_model #(
    parameter logic [6:0] dev_addr = 7'h50
) (
    input  wire clk,
    input  wire rst,
    input  wire scl,
    inout  tri  sda
);

    typedef enum logic [2:0] {
        m_idle,   // Not addressed, wait for START
        m_addr,
        m_reg,
        m_wdata,
        m_rdata
    } slave_mode_t;

    slave_mode_t mode;
    logic [7:0]  regs [256];
    logic [7:0]  shreg;
    logic [7:0]  tx_byte;
    logic [7:0]  reg_ptr;
    logic [3:0]  bit_cnt;    // 8 is the ACK slot of a read, 9 of a write
    logic        rw_bit;
    logic        sda_low;
    logic        scl_q, sda_q;
    logic        start_det, stop_det, scl_rise, scl_fall;

    assign sda = sda_low ? 1'b0 : 1'bz;

    assign start_det = scl_q && scl && sda_q && !sda;
    assign stop_det  = scl_q && scl && !sda_q && sda;
    assign scl_rise  = !scl_q && scl;
    assign scl_fall  = scl_q && !scl;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 256; i++) begin
                regs[i] <= 8'h00;
            end
            mode    <= m_idle;
            shreg   <= 8'h00;
            tx_byte <= 8'h00;
            reg_ptr <= 8'h00;
            bit_cnt <= 4'd0;
            rw_bit  <= 1'b0;
            sda_low <= 1'b0;
            scl_q   <= 1'b1;
            sda_q   <= 1'b1;
        end else begin
            scl_q <= scl;
            sda_q <= sda;
            if (start_det) begin
                mode    <= m_addr;  // Also a repeated START
                bit_cnt <= 4'd0;
                sda_low <= 1'b0;
            end else if (stop_det) begin
                mode    <= m_idle;
                sda_low <= 1'b0;
            end else if (scl_rise) begin
                if (mode == m_rdata) begin
                    if (bit_cnt < 4'd8) begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end else begin
                        mode <= m_idle;  // Master ACK slot ends the byte
                    end
                end else if (mode != m_idle && bit_cnt < 4'd8) begin
                    shreg   <= {shreg[6:0], sda};
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else if (scl_fall) begin
                if (mode == m_rdata) begin
                    if (bit_cnt == 4'd8) begin
                        sda_low <= 1'b0;  // Let the master answer
                    end else begin
                        sda_low <= ~tx_byte[6];
                        tx_byte <= {tx_byte[6:0], 1'b0};
                    end
                end else if (mode != m_idle && bit_cnt == 4'd8) begin
                    bit_cnt <= 4'd9;
                    sda_low <= 1'b1;  // ACK unless the address misses
                    case (mode)
                        m_addr: begin
                            if (shreg[7:1] == dev_addr) begin
                                rw_bit <= shreg[0];
                            end else begin
                                mode    <= m_idle;
                                sda_low <= 1'b0;
                            end
                        end
                        m_reg: reg_ptr <= shreg;
                        m_wdata: begin
                            regs[reg_ptr] <= shreg;
                            reg_ptr       <= reg_ptr + 1'b1;
                        end
                        default: ;
                    endcase
                end else if (mode != m_idle && bit_cnt == 4'd9) begin
                    sda_low <= 1'b0;
                    bit_cnt <= 4'd0;
                    case (mode)
                        m_addr: begin
                            if (rw_bit) begin
                                mode    <= m_rdata;
                                tx_byte <= regs[reg_ptr];
                                sda_low <= ~regs[reg_ptr][7];  // MSB out right away
                            end else begin
                                mode <= m_reg;
                            end
                        end
                        m_reg: mode <= m_wdata;
                        default: ;
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/i2c_stimulus.txt
# rw dev_addr reg_addr wdata exp_rdata exp_nack, all hex, one request per line
# writes expect rdata 00, reads carry wdata 00
0 50 10 a5 00 0
1 50 10 00 a5 0
0 50 20 3c 00 0
0 50 20 c3 00 0
1 50 20 00 c3 0
0 51 10 ff 00 1
1 50 10 00 a5 0
1 23 10 00 00 1
1 50 7f 00 00 0
0 50 00 01 00 0
0 50 ff 80 00 0
1 50 ff 00 80 0
1 50 00 00 01 0
1 50 80 00 00 0
0 50 10 5a 00 0
1 50 10 00 5a 0
0 7f 20 00 00 1
1 50 20 00 c3 0

//--- dv/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen #(
    parameter int period       = 4,
    parameter int reset_cycles = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // Release a little after the rising edge
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- dv/tb_i2c_subsys.sv
`default_nettype none

module tb_i2c_subsys import i2c_pkg::*; ();

    typedef struct packed {
        i2c_req_t req;
        i2c_rsp_t rsp;  // Expected response
    } vector_t;

    logic     clk, rst;
    i2c_req_t req;
    logic     req_strobe;
    logic     busy, done;
    i2c_rsp_t rsp;
    tri       scl, sda;

    vector_t     vectors [$];
    int          cur_vec = 0;
    int unsigned cycle_cnt = 0;
    int unsigned cycle_limit = 32'hffff_ffff;

    pullup (scl);
    pullup (sda);

    tb_clk_gen #(.period(4), .reset_cycles(8)) tb_clk_gen_i (.clk(clk), .rst(rst));

    i2c_subsys_top i2c_subsys_top_i (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .req_strobe (req_strobe),
        .busy       (busy),
        .done       (done),
        .rsp        (rsp),
        .scl        (scl),
        .sda        (sda)
    );

    i2c_slave_model #(.dev_addr(7'h50)) i2c_slave_model_i (
        .clk (clk),
        .rst (rst),
        .scl (scl),
        .sda (sda)
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: request %0d got no done within %0d cycles", cur_vec, cycle_limit);
            $display("Test FAILED");
            $fatal(1, "Simulation timed out");
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h (request %0d)",
                     name, actual, expected, cur_vec);
            $display("Test FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    // Strobe one request, then wait for its done pulse
    task automatic run_request(input vector_t vec);
        @(posedge clk);
        #1;
        req        = vec.req;
        req_strobe = 1'b1;
        @(posedge clk);
        #1;
        req_strobe = 1'b0;
        check_value("busy", 32'(busy), 32'h1);
        while (done !== 1'b1) begin
            @(negedge clk);
        end
        check_value("busy", 32'(busy), 32'h1);
        check_value("rsp.rdata", 32'(rsp.rdata), 32'(vec.rsp.rdata));
        check_value("rsp.nack", 32'(rsp.nack), 32'(vec.rsp.nack));
    endtask

    initial begin
        int               fd;
        int               n_fields;
        logic [8*128-1:0] line;
        logic             f_rw;
        logic [6:0]       f_dev;
        logic [7:0]       f_reg, f_wdata, f_rdata;
        logic             f_nack;
        vector_t          vec;

        req        = '0;
        req_strobe = 1'b0;

        fd = $fopen("dv/i2c_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Cannot open stimulus file dv/i2c_stimulus.txt");
            $display("Test FAILED");
            $fatal(1, "Missing stimulus file");
        end
        while ($fgets(line, fd) != 0) begin
            // Comment and blank lines match no field
            n_fields = $sscanf(line, "%h %h %h %h %h %h",
                               f_rw, f_dev, f_reg, f_wdata, f_rdata, f_nack);
            if (n_fields == 6) begin
                vec.req.rw       = f_rw;
                vec.req.dev_addr = f_dev;
                vec.req.reg_addr = f_reg;
                vec.req.wdata    = f_wdata;
                vec.rsp.rdata    = f_rdata;
                vec.rsp.nack     = f_nack;
                vectors.push_back(vec);
            end
        end
        $fclose(fd);
        if (vectors.size() == 0) begin
            $display("Stimulus file holds no requests");
            $display("Test FAILED");
            $fatal(1, "Empty stimulus file");
        end
        cycle_limit = vectors.size() * 8 * 400 + 100;  // 8 ops of at most 400 clocks

        @(negedge rst);
        @(negedge clk);
        check_value("busy", 32'(busy), 32'h0);
        check_value("done", 32'(done), 32'h0);
        check_value("scl", 32'(scl), 32'h1);  // Bus idle after reset
        check_value("sda", 32'(sda), 32'h1);

        foreach (vectors[i]) begin
            cur_vec = i;
            run_request(vectors[i]);
        end

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/i2c_bit_engine.sv
`default_nettype none

module i2c_bit_engine import i2c_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  i2c_op_t    op,
    input  logic       op_strobe,
    output logic       op_busy,
    output logic       op_done,
    output logic       ack_in,
    output logic [7:0] rx_byte,
    inout  tri         scl,
    inout  tri         sda
);

    typedef enum logic [4:0] {
        st_idle,
        st_start1, st_start2, st_start3,
        st_wr1, st_wr2, st_wr3, st_wr4,
        st_rd1, st_rd2, st_rd3, st_rd4,
        st_ack1, st_ack2, st_ack3, st_ack4,
        st_stop1, st_stop2, st_stop3
    } eng_state_t;

    eng_state_t state, state_next;

    // Open-drain line control, 1 pulls the line low
    logic scl_low, sda_low;
    logic sda_in;

    assign scl    = scl_low ? 1'b0 : 1'bz;
    assign sda    = sda_low ? 1'b0 : 1'bz;
    assign sda_in = sda;

    logic [7:0] tx_buf, tx_next;
    logic [7:0] rx_buf, rx_next;
    logic [2:0] bit_cnt, bit_next;
    logic       ack_low, ack_low_next;  // Pull SDA low in the ACK slot
    logic       ack_q, ack_next;
    logic       scl_hold, hold_next;    // Keep SCL low between ops
    logic       done_next;

    tick_cnt_t clk_cnt;
    logic      tick;

    assign tick =
        ((state inside {st_start1, st_start2, st_start3, st_stop1, st_stop2, st_stop3})
            && (clk_cnt == tick_cnt_t'(tick_half_count - 1))) ||
        ((state inside {st_wr1, st_wr2, st_wr3, st_wr4, st_rd1, st_rd2, st_rd3, st_rd4,
                        st_ack1, st_ack2, st_ack3, st_ack4})
            && (clk_cnt == tick_cnt_t'(tick_quarter_count - 1)));

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            clk_cnt <= '0;
        end else if (tick || state == st_idle) begin
            clk_cnt <= '0;
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state    <= st_idle;
            bit_cnt  <= 3'd0;
            scl_hold <= 1'b0;
            op_done  <= 1'b0;
        end else begin
            state    <= state_next;
            bit_cnt  <= bit_next;
            scl_hold <= hold_next;
            op_done  <= done_next;
        end
    end

    always_ff @(posedge clk) begin
        tx_buf  <= tx_next;
        rx_buf  <= rx_next;
        ack_low <= ack_low_next;
        ack_q   <= ack_next;
    end

    always_comb begin
        state_next   = state;
        tx_next      = tx_buf;
        rx_next      = rx_buf;
        bit_next     = bit_cnt;
        ack_low_next = ack_low;
        ack_next     = ack_q;
        hold_next    = scl_hold;
        done_next    = 1'b0;
        scl_low      = 1'b1;
        sda_low      = 1'b0;

        case (state)
            st_idle: begin
                scl_low = scl_hold;
                if (op_strobe) begin
                    tx_next      = op.wbyte;
                    bit_next     = 3'd0;
                    ack_low_next = (op.cmd == cmd_read) && !op.ack_out;
                    case (op.cmd)
                        cmd_start: state_next = st_start1;
                        cmd_write: state_next = st_wr1;
                        cmd_read:  state_next = st_rd1;
                        default:   state_next = st_stop1;
                    endcase
                end
            end

            // START, also a repeated START when entered with SCL low
            st_start1: begin
                scl_low = 1'b0;
                if (tick) state_next = st_start2;
            end
            st_start2: begin
                scl_low = 1'b0;
                sda_low = 1'b1;  // SDA falls while SCL high
                if (tick) state_next = st_start3;
            end
            st_start3: begin
                sda_low = 1'b1;
                if (tick) begin
                    state_next = st_idle;
                    hold_next  = 1'b1;
                    done_next  = 1'b1;
                end
            end

            st_wr1: begin
                sda_low = ~tx_buf[7];  // Data changes with SCL low
                if (tick) state_next = st_wr2;
            end
            st_wr2: begin
                scl_low = 1'b0;
                sda_low = ~tx_buf[7];
                if (tick) state_next = st_wr3;
            end
            st_wr3: begin
                scl_low = 1'b0;
                sda_low = ~tx_buf[7];
                if (tick) state_next = st_wr4;
            end
            st_wr4: begin
                sda_low = ~tx_buf[7];
                if (tick) begin
                    if (bit_cnt == 3'd7) begin
                        state_next = st_ack1;
                    end else begin
                        tx_next    = {tx_buf[6:0], 1'b0};
                        bit_next   = bit_cnt + 1'b1;
                        state_next = st_wr1;
                    end
                end
            end

            // SDA released, slave drives the bit
            st_rd1: begin
                if (tick) state_next = st_rd2;
            end
            st_rd2: begin
                scl_low = 1'b0;
                if (tick) begin
                    rx_next    = {rx_buf[6:0], sda_in};  // MSB first
                    state_next = st_rd3;
                end
            end
            st_rd3: begin
                scl_low = 1'b0;
                if (tick) state_next = st_rd4;
            end
            st_rd4: begin
                if (tick) begin
                    if (bit_cnt == 3'd7) begin
                        state_next = st_ack1;
                    end else begin
                        bit_next   = bit_cnt + 1'b1;
                        state_next = st_rd1;
                    end
                end
            end

            // ACK slot, slave answers a write, master answers a read
            st_ack1: begin
                sda_low = ack_low;
                if (tick) state_next = st_ack2;
            end
            st_ack2: begin
                scl_low = 1'b0;
                sda_low = ack_low;
                if (tick) begin
                    ack_next   = sda_in;
                    state_next = st_ack3;
                end
            end
            st_ack3: begin
                scl_low = 1'b0;
                sda_low = ack_low;
                if (tick) state_next = st_ack4;
            end
            st_ack4: begin
                sda_low = ack_low;
                if (tick) begin
                    state_next = st_idle;
                    hold_next  = 1'b1;
                    done_next  = 1'b1;
                end
            end

            st_stop1: begin
                sda_low = 1'b1;
                if (tick) state_next = st_stop2;
            end
            st_stop2: begin
                scl_low = 1'b0;
                sda_low = 1'b1;
                if (tick) state_next = st_stop3;
            end
            st_stop3: begin
                scl_low = 1'b0;  // SDA rose while SCL high, bus free
                if (tick) begin
                    state_next = st_idle;
                    hold_next  = 1'b0;
                    done_next  = 1'b1;
                end
            end

            default: state_next = st_idle;
        endcase
    end

    assign op_busy = (state != st_idle);
    assign ack_in  = ack_q;
    assign rx_byte = rx_buf;

endmodule

`default_nettype wire

//--- hdl/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

    // Bus timing in system clocks, kept small for simulation
    localparam int tick_half_count    = 20;  // START/STOP phase
    localparam int tick_quarter_count = 10;  // One quarter of a data bit

    // Tick counter sized for the longer phase
    localparam int tick_cnt_w = $clog2(tick_half_count);
    typedef logic [tick_cnt_w-1:0] tick_cnt_t;

    // Byte-level commands accepted by the bit engine
    typedef enum logic [1:0] {
        cmd_start,
        cmd_write,
        cmd_read,
        cmd_stop
    } i2c_cmd_t;

    typedef struct packed {
        i2c_cmd_t   cmd;
        logic [7:0] wbyte;    // Byte shifted out by cmd_write
        logic       ack_out;  // Level in the ACK slot of cmd_read, 0 is ACK
    } i2c_op_t;

    // Host register request
    typedef struct packed {
        logic       rw;        // 1 for read
        logic [6:0] dev_addr;
        logic [7:0] reg_addr;
        logic [7:0] wdata;
    } i2c_req_t;

    typedef struct packed {
        logic [7:0] rdata;
        logic       nack;
    } i2c_rsp_t;

endpackage

`default_nettype wire

//--- hdl/i2c_reg_sequencer.sv
`default_nettype none

module i2c_reg_sequencer import i2c_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  i2c_req_t   req,
    input  logic       req_strobe,
    output logic       busy,
    output logic       done,
    output i2c_rsp_t   rsp,
    output i2c_op_t    op,
    output logic       op_strobe,
    input  logic       op_busy,
    input  logic       op_done,
    input  logic       ack_in,
    input  logic [7:0] rx_byte
);

    typedef enum logic [1:0] {
        seq_idle,
        seq_issue,
        seq_wait,
        seq_done
    } seq_state_t;

    seq_state_t state;
    logic [2:0] step;       // Index into the op list of the request
    logic [2:0] stop_step;
    i2c_req_t   req_q;
    i2c_rsp_t   rsp_q;

    assign stop_step = req_q.rw ? 3'd6 : 3'd4;

    // Write: start, addr+W, reg, wdata, stop
    // Read:  start, addr+W, reg, start, addr+R, read, stop
    always_comb begin
        op.cmd     = cmd_stop;
        op.wbyte   = 8'h00;
        op.ack_out = 1'b1;  // Single byte read ends with NACK
        case (step)
            3'd0: op.cmd = cmd_start;
            3'd1: begin
                op.cmd   = cmd_write;
                op.wbyte = {req_q.dev_addr, 1'b0};
            end
            3'd2: begin
                op.cmd   = cmd_write;
                op.wbyte = req_q.reg_addr;
            end
            3'd3: begin
                if (req_q.rw) begin
                    op.cmd = cmd_start;  // Repeated START
                end else begin
                    op.cmd   = cmd_write;
                    op.wbyte = req_q.wdata;
                end
            end
            3'd4: begin
                if (req_q.rw) begin
                    op.cmd   = cmd_write;
                    op.wbyte = {req_q.dev_addr, 1'b1};
                end
            end
            3'd5: op.cmd = cmd_read;
            default: op.cmd = cmd_stop;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == seq_idle && req_strobe) begin
            req_q <= req;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= seq_idle;
            step  <= 3'd0;
            rsp_q <= '0;
        end else begin
            case (state)
                seq_idle: begin
                    if (req_strobe) begin
                        rsp_q <= '0;
                        step  <= 3'd0;
                        state <= seq_issue;
                    end
                end
                seq_issue: begin
                    if (!op_busy) state <= seq_wait;
                end
                seq_wait: begin
                    if (op_done) begin
                        if (op.cmd == cmd_stop) begin
                            state <= seq_done;
                        end else if (op.cmd == cmd_write && ack_in) begin
                            rsp_q.nack <= 1'b1;  // No ACK, close the transfer
                            step       <= stop_step;
                            state      <= seq_issue;
                        end else begin
                            if (op.cmd == cmd_read) rsp_q.rdata <= rx_byte;
                            step  <= step + 1'b1;
                            state <= seq_issue;
                        end
                    end
                end
                default: state <= seq_idle;
            endcase
        end
    end

    assign op_strobe = (state == seq_issue) && !op_busy;
    assign busy      = (state != seq_idle);
    assign done      = (state == seq_done);
    assign rsp       = rsp_q;

endmodule

`default_nettype wire

//--- hdl/i2c_subsys_top.sv
`default_nettype none

module i2c_subsys_top import i2c_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  i2c_req_t req,
    input  logic     req_strobe,
    output logic     busy,
    output logic     done,
    output i2c_rsp_t rsp,
    inout  tri       scl,
    inout  tri       sda
);

    // Sequencer to engine command path
    i2c_op_t    op;
    logic       op_strobe;
    logic       op_busy;
    logic       op_done;
    logic       ack_in;
    logic [7:0] rx_byte;

    i2c_reg_sequencer i2c_reg_sequencer_i (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .req_strobe (req_strobe),
        .busy       (busy),
        .done       (done),
        .rsp        (rsp),
        .op         (op),
        .op_strobe  (op_strobe),
        .op_busy    (op_busy),
        .op_done    (op_done),
        .ack_in     (ack_in),
        .rx_byte    (rx_byte)
    );

    i2c_bit_engine i2c_bit_engine_i (
        .clk       (clk),
        .rst       (rst),
        .op        (op),
        .op_strobe (op_strobe),
        .op_busy   (op_busy),
        .op_done   (op_done),
        .ack_in    (ack_in),
        .rx_byte   (rx_byte),
        .scl       (scl),  // Open-drain pins
        .sda       (sda)
    );

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build and run the I2C testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module tb_i2c_subsys \
    -f verilog.f \
    -o sim_tb_i2c_subsys

./obj_dir/sim_tb_i2c_subsys

//--- verilog.f
hdl/i2c_pkg.sv
hdl/i2c_bit_engine.sv
hdl/i2c_reg_sequencer.sv
hdl/i2c_subsys_top.sv
dv/tb_clk_gen.sv
dv/i2c_slave_model.sv
dv/tb_i2c_subsys.sv
